// ==== sim/tb_input.txt ====
# first value: number of status reads answered with 0x00 before UDP
# then one word per line: idle cycles before the strobe, payload word in hex
3
0 0123456789ABCDEF
0 1122334455667788
0 A5A5A5A55A5A5A5A
0 FEDCBA9876543210
0 DEADBEEFCAFEF00D
0 0000000000000001
3000 8000000000000000
400 0F1E2D3C4B5A6978
400 FFFFFFFFFFFFFFFF

// ==== tb.f ====
common/w5500_pkg.sv
logic/payload_fifo.sv
sequencer/frame_sequencer.sv
spi/spi_shifter.sv
logic/w5500_tx_top.sv
sim/w5500_slave_model.sv
sim/tb_w5500.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_w5500
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/tb_w5500.sv ====
`default_nettype none

module tb_w5500;
    import w5500_pkg::*;

    localparam int RESET_CYCLES = 5;
    localparam int MARGIN_CYCLES = 200;
    localparam int DRAIN_CYCLES = 2 * FRAME_BITS + 4;
    localparam int KIND_CMD = 0;
    localparam int KIND_STATUS = 1;
    localparam int KIND_PTR_LO = 2;
    localparam int KIND_PTR_HI = 3;

    logic       clk;
    logic       rst_n;
    logic       tx_valid;
    payload_t   tx_data;
    logic       miso;
    logic       mosi;
    logic       sclk;
    logic       cs_n;
    logic       init_done;
    logic       overflow;
    logic [7:0] non_udp_reads;
    frame_t     cap_frame;
    frame_len_t cap_len;
    int         cap_count;

    frame_t     exp_frame_q[$];
    frame_len_t exp_len_q[$];
    int         exp_kind_q[$];
    ptr_t       exp_ptr_q[$];
    int         gap_q[$];
    payload_t   word_q[$];

    int    errors = 0;
    int    checks = 0;
    int    seen_count = 0;
    int    status_seen = 0;
    int    packets = 0;
    int    setup_accepted = 0;
    int    drops_exp = 0;
    int    drops_seen = 0;
    int    num_non_udp = 0;
    int    watchdog_cycles = 0;
    logic  check_init = 1'b0;
    logic  cfg_ready = 1'b0;
    byte_t ptr_lo = '0;

    always #5 clk = ~clk;

    w5500_tx_top i_w5500_tx_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .tx_valid  (tx_valid),
        .tx_data   (tx_data),
        .miso      (miso),
        .mosi      (mosi),
        .sclk      (sclk),
        .cs_n      (cs_n),
        .init_done (init_done),
        .overflow  (overflow)
    );

    w5500_slave_model i_slave (
        .sclk          (sclk),
        .mosi          (mosi),
        .cs_n          (cs_n),
        .non_udp_reads (non_udp_reads),
        .miso          (miso),
        .frame         (cap_frame),
        .frame_len     (cap_len),
        .frame_count   (cap_count)
    );

    task automatic compare_frame(input frame_t act, input frame_len_t act_len,
                                 input frame_t exp, input frame_len_t exp_len,
                                 input string what);
        checks++;
        if (act !== exp || act_len !== exp_len) begin
            errors++;
            $display("ERROR at %0t: %s frame %h (%0d bits), expected %h (%0d bits)",
                     $time, what, act, act_len, exp, exp_len);
        end
    endtask

    task automatic compare_ptr(input ptr_t act, input ptr_t exp, input string what);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, act, exp);
        end
    endtask

    task automatic compare_flag(input logic act, input logic exp, input string what);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR at %0t: %s is %b, expected %b", $time, what, act, exp);
        end
    endtask

    task automatic expect_cmd(input logic [15:0] addr, input ctrl_t ctrl,
                              input byte_t data, input int kind);
        exp_frame_q.push_back({addr, ctrl, data, {(FRAME_BITS - CMD_BITS){1'b0}}});
        exp_len_q.push_back(frame_len_t'(CMD_BITS));
        exp_kind_q.push_back(kind);
    endtask

    task automatic build_setup();
        expect_cmd(REG_PHYCFGR, CTRL_COMMON_WRITE, PHY_MODE, KIND_CMD);
        for (int i = 0; i < 6; i++) begin
            expect_cmd(REG_SHAR + 16'(i), CTRL_COMMON_WRITE, MAC_ADDR[47-8*i -: 8], KIND_CMD);
        end
        for (int i = 0; i < 4; i++) begin
            expect_cmd(REG_SIPR + 16'(i), CTRL_COMMON_WRITE, LOCAL_IP[31-8*i -: 8], KIND_CMD);
        end
        for (int i = 0; i < 4; i++) begin
            expect_cmd(REG_GAR + 16'(i), CTRL_COMMON_WRITE, GATEWAY_IP[31-8*i -: 8], KIND_CMD);
        end
        for (int i = 0; i < 4; i++) begin
            expect_cmd(REG_SUBR + 16'(i), CTRL_COMMON_WRITE, SUBNET_MASK[31-8*i -: 8],
                       KIND_CMD);
        end
        expect_cmd(REG_S0_MR, CTRL_S0_WRITE, S0_MODE_UDP, KIND_CMD);
        expect_cmd(REG_S0_RXBUF_SIZE, CTRL_S0_WRITE, S0_BUF_KB, KIND_CMD);
        expect_cmd(REG_S0_TXBUF_SIZE, CTRL_S0_WRITE, S0_BUF_KB, KIND_CMD);
        expect_cmd(REG_S0_PORT, CTRL_S0_WRITE, SRC_PORT[15:8], KIND_CMD);
        expect_cmd(REG_S0_PORT + 16'd1, CTRL_S0_WRITE, SRC_PORT[7:0], KIND_CMD);
        expect_cmd(REG_S0_CR, CTRL_S0_WRITE, CMD_OPEN, KIND_CMD);
        for (int i = 0; i < 4; i++) begin
            expect_cmd(REG_S0_DIPR + 16'(i), CTRL_S0_WRITE, DST_IP[31-8*i -: 8], KIND_CMD);
        end
        expect_cmd(REG_S0_DPORT, CTRL_S0_WRITE, DST_PORT[15:8], KIND_CMD);
        expect_cmd(REG_S0_DPORT + 16'd1, CTRL_S0_WRITE, DST_PORT[7:0], KIND_CMD);
        for (int i = 0; i <= num_non_udp; i++) begin
            expect_cmd(REG_S0_SR, CTRL_S0_READ, 8'h00, KIND_STATUS);
        end
    endtask

    task automatic expect_packet(input payload_t word);
        ptr_t base;
        ptr_t next;
        base = ptr_t'(packets * (PAYLOAD_BITS / 8));
        next = base + ptr_t'(PAYLOAD_BITS / 8);
        exp_frame_q.push_back({base, CTRL_S0_TX_WRITE, word});
        exp_len_q.push_back(frame_len_t'(FRAME_BITS));
        exp_kind_q.push_back(KIND_CMD);
        expect_cmd(REG_S0_TX_WR_LO, CTRL_S0_WRITE, next[7:0], KIND_PTR_LO);
        expect_cmd(REG_S0_TX_WR_HI, CTRL_S0_WRITE, next[15:8], KIND_PTR_HI);
        exp_ptr_q.push_back(next);
        expect_cmd(REG_S0_CR, CTRL_S0_WRITE, CMD_SEND, KIND_CMD);
        packets++;
    endtask

    task automatic read_stimulus();
        int       fd;
        int       gap;
        logic     have_k;
        string    line;
        payload_t word;
        have_k = 1'b0;
        fd = $fopen("sim/tb_input.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the stimulus file sim/tb_input.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() == 0 || line.getc(0) == 8'h23) begin
                    continue;
                end
                if (!have_k) begin
                    if ($sscanf(line, "%d", num_non_udp) == 1) begin
                        have_k = 1'b1;
                    end
                end else if ($sscanf(line, "%d %h", gap, word) == 2) begin
                    gap_q.push_back(gap);
                    word_q.push_back(word);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic handle_frame();
        int kind;
        if (exp_len_q.size() == 0) begin
            errors++;
            $display("An unexpected frame of %0d bits came after the expected sequence",
                     cap_len);
        end else begin
            kind = exp_kind_q.pop_front();
            compare_frame(cap_frame, cap_len, exp_frame_q.pop_front(), exp_len_q.pop_front(),
                          "SPI");
            case (kind)
                KIND_STATUS: begin
                    compare_flag(init_done, 1'b0, "init_done during status poll");
                    status_seen++;
                    if (status_seen == num_non_udp + 1) begin
                        check_init = 1'b1;
                    end
                end
                KIND_PTR_LO: ptr_lo = cap_frame[FRAME_BITS-25 -: 8];
                KIND_PTR_HI: compare_ptr({cap_frame[FRAME_BITS-25 -: 8], ptr_lo},
                                         exp_ptr_q.pop_front(), "TX write pointer");
                default: ;
            endcase
        end
    endtask

    // Frames are picked up mid-cycle, after the slave has latched them
    always @(negedge clk) begin
        if (check_init) begin
            compare_flag(init_done, 1'b1, "init_done after the UDP status read");
            check_init = 1'b0;
        end
        if (rst_n && cap_count != seen_count) begin
            seen_count = cap_count;
            handle_frame();
        end
    end

    // Every overflow pulse counts, also one without a strobe
    always @(posedge clk) begin
        if (rst_n && overflow === 1'b1) begin
            drops_seen++;
        end
    end

    initial begin
        int gap_sum;
        logic exp_drop;
        logic in_setup;
        clk = 1'b0;
        rst_n = 1'b0;
        tx_valid = 1'b0;
        tx_data = '0;
        non_udp_reads = '0;
        read_stimulus();
        non_udp_reads = 8'(num_non_udp);
        build_setup();
        gap_sum = 0;
        foreach (gap_q[i]) begin
            gap_sum += gap_q[i];
        end
        watchdog_cycles = (SETUP_STEPS + num_non_udp + 1) * (2 * CMD_BITS + 1)
                        + word_q.size() * (2 * FRAME_BITS + 1 + 3 * (2 * CMD_BITS + 1))
                        + gap_sum + RESET_CYCLES + MARGIN_CYCLES;
        cfg_ready = 1'b1;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            compare_flag(cs_n, 1'b1, "cs_n in reset");
            compare_flag(sclk, 1'b0, "sclk in reset");
            compare_flag(init_done, 1'b0, "init_done in reset");
        end
        rst_n = 1'b1;
        for (int i = 0; i < word_q.size(); i++) begin
            if (gap_q[i] > 0) begin
                tx_valid = 1'b0;
                repeat (gap_q[i]) @(negedge clk);
            end
            // No pop happens before the UDP status read, so early words fill the FIFO
            in_setup = status_seen <= num_non_udp;
            exp_drop = in_setup && setup_accepted >= FIFO_DEPTH;
            tx_valid = 1'b1;
            tx_data = word_q[i];
            #1;
            compare_flag(overflow, exp_drop, "overflow on strobe");
            if (exp_drop) begin
                drops_exp++;
            end else begin
                expect_packet(word_q[i]);
                if (in_setup) begin
                    setup_accepted++;
                end
            end
            @(negedge clk);
        end
        tx_valid = 1'b0;
        while (exp_len_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (DRAIN_CYCLES) @(negedge clk);
        compare_flag(drops_seen == drops_exp, 1'b1, "overflow pulse count match");
        $display("Checks: %0d, errors: %0d, frames: %0d, packets: %0d, drops: %0d",
                 checks, errors, seen_count, packets, drops_seen);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        wait (cfg_ready);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/w5500_slave_model.sv ====
`default_nettype none

module w5500_slave_model (
    input  logic                  sclk,
    input  logic                  mosi,
    input  logic                  cs_n,
    input  logic [7:0]            non_udp_reads,
    output logic                  miso,
    output w5500_pkg::frame_t     frame,
    output w5500_pkg::frame_len_t frame_len,
    output int                    frame_count
);
    import w5500_pkg::*;

    frame_t      shreg;
    int          nbits;
    logic [23:0] header;
    int          status_reads;
    byte_t       answer;
    logic        is_status;

    initial begin
        shreg = '0;
        nbits = 0;
        header = '0;
        status_reads = 0;
        frame = '0;
        frame_len = '0;
        frame_count = 0;
    end

    assign is_status = (nbits >= 24) && (header == {REG_S0_SR, CTRL_S0_READ});
    assign answer = (status_reads < int'(non_udp_reads)) ? 8'h00 : SOCK_UDP;

    // Data byte of a status read goes out MSB first after the 24 header bits
    assign miso = (is_status && nbits < 32) ? answer[3'(31 - nbits)] : 1'b0;

    always @(posedge sclk or posedge cs_n) begin
        if (cs_n) begin
            if (nbits > 0) begin
                frame <= shreg << (FRAME_BITS - nbits);
                frame_len <= frame_len_t'(nbits);
                frame_count <= frame_count + 1;
                if (is_status) begin
                    status_reads <= status_reads + 1;
                end
            end
            shreg <= '0;
            nbits <= 0;
            header <= '0;
        end else begin
            shreg <= {shreg[FRAME_BITS-2:0], mosi};
            nbits <= nbits + 1;
            if (nbits < 24) begin
                header <= {header[22:0], mosi};
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/w5500_tx_top.sv ====
`default_nettype none

module w5500_tx_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                tx_valid,
    input  w5500_pkg::payload_t tx_data,
    input  logic                miso,
    output logic                mosi,
    output logic                sclk,
    output logic                cs_n,
    output logic                init_done,
    output logic                overflow
);
    import w5500_pkg::*;

    payload_t   head;
    logic       empty;
    logic       pop;
    logic       start;
    frame_t     frame;
    frame_len_t frame_len;
    logic       done;
    byte_t      rd_byte;

    payload_fifo i_payload_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (tx_valid),
        .wdata    (tx_data),
        .pop      (pop),
        .head     (head),
        .empty    (empty),
        .overflow (overflow)
    );

    frame_sequencer i_frame_sequencer (
        .clk       (clk),
        .rst_n     (rst_n),
        .empty     (empty),
        .head      (head),
        .pop       (pop),
        .start     (start),
        .frame     (frame),
        .frame_len (frame_len),
        .done      (done),
        .rd_byte   (rd_byte),
        .init_done (init_done)
    );

    spi_shifter i_spi_shifter (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .frame     (frame),
        .frame_len (frame_len),
        .done      (done),
        .rd_byte   (rd_byte),
        .sclk      (sclk),
        .mosi      (mosi),
        .cs_n      (cs_n),
        .miso      (miso)
    );

endmodule

`default_nettype wire

// ==== spi/spi_shifter.sv ====
`default_nettype none

module spi_shifter (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  w5500_pkg::frame_t     frame,
    input  w5500_pkg::frame_len_t frame_len,
    output logic                  done,
    output w5500_pkg::byte_t      rd_byte,
    output logic                  sclk,
    output logic                  mosi,
    output logic                  cs_n,
    input  logic                  miso
);
    import w5500_pkg::*;

    logic       busy;
    frame_t     shreg;
    frame_len_t len_q;
    frame_len_t edge_cnt;
    logic       last_edge;

    // Falling edge after the final rising edge ends the frame
    assign last_edge = busy && sclk && (edge_cnt == len_q);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            sclk <= 1'b0;
            mosi <= 1'b0;
            cs_n <= 1'b1;
            done <= 1'b0;
            edge_cnt <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cs_n <= 1'b0;
                sclk <= 1'b0;
                mosi <= frame[FRAME_BITS-1];
                edge_cnt <= '0;
            end else if (busy) begin
                sclk <= ~sclk;
                if (!sclk) begin
                    edge_cnt <= edge_cnt + 1'b1;
                end else if (last_edge) begin
                    busy <= 1'b0;
                    cs_n <= 1'b1;
                    done <= 1'b1;
                    mosi <= 1'b0;
                end else begin
                    mosi <= shreg[FRAME_BITS-1];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            shreg <= frame << 1;
            len_q <= frame_len;
        end else if (busy && sclk && !last_edge) begin
            shreg <= shreg << 1;
        end
        // Sample miso as sclk rises, the slave drives it after the fall
        if (busy && !sclk) begin
            rd_byte <= {rd_byte[6:0], miso};
        end
    end

    a_no_start_while_busy: assert property (
        @(posedge clk) disable iff (!rst_n) start |-> !busy
    );

    a_cs_low_for_frame: assert property (
        @(posedge clk) disable iff (!rst_n) start |=> !cs_n until done
    );

endmodule

`default_nettype wire

// ==== sequencer/frame_sequencer.sv ====
`default_nettype none

module frame_sequencer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  empty,
    input  w5500_pkg::payload_t   head,
    output logic                  pop,
    output logic                  start,
    output w5500_pkg::frame_t     frame,
    output w5500_pkg::frame_len_t frame_len,
    input  logic                  done,
    input  w5500_pkg::byte_t      rd_byte,
    output logic                  init_done
);
    import w5500_pkg::*;

    seq_state_t          state;
    logic [4:0]          step;
    logic                in_flight;
    ptr_t                tx_ptr;
    payload_t            payload_q;
    logic [CMD_BITS-1:0] cmd;

    function automatic logic [CMD_BITS-1:0] setup_cmd(input logic [4:0] idx);
        logic [CMD_BITS-1:0] c;
        case (idx)
            5'd0:    c = {REG_PHYCFGR, CTRL_COMMON_WRITE, PHY_MODE};
            5'd1:    c = {REG_SHAR, CTRL_COMMON_WRITE, MAC_ADDR[47:40]};
            5'd2:    c = {REG_SHAR + 16'd1, CTRL_COMMON_WRITE, MAC_ADDR[39:32]};
            5'd3:    c = {REG_SHAR + 16'd2, CTRL_COMMON_WRITE, MAC_ADDR[31:24]};
            5'd4:    c = {REG_SHAR + 16'd3, CTRL_COMMON_WRITE, MAC_ADDR[23:16]};
            5'd5:    c = {REG_SHAR + 16'd4, CTRL_COMMON_WRITE, MAC_ADDR[15:8]};
            5'd6:    c = {REG_SHAR + 16'd5, CTRL_COMMON_WRITE, MAC_ADDR[7:0]};
            5'd7:    c = {REG_SIPR, CTRL_COMMON_WRITE, LOCAL_IP[31:24]};
            5'd8:    c = {REG_SIPR + 16'd1, CTRL_COMMON_WRITE, LOCAL_IP[23:16]};
            5'd9:    c = {REG_SIPR + 16'd2, CTRL_COMMON_WRITE, LOCAL_IP[15:8]};
            5'd10:   c = {REG_SIPR + 16'd3, CTRL_COMMON_WRITE, LOCAL_IP[7:0]};
            5'd11:   c = {REG_GAR, CTRL_COMMON_WRITE, GATEWAY_IP[31:24]};
            5'd12:   c = {REG_GAR + 16'd1, CTRL_COMMON_WRITE, GATEWAY_IP[23:16]};
            5'd13:   c = {REG_GAR + 16'd2, CTRL_COMMON_WRITE, GATEWAY_IP[15:8]};
            5'd14:   c = {REG_GAR + 16'd3, CTRL_COMMON_WRITE, GATEWAY_IP[7:0]};
            5'd15:   c = {REG_SUBR, CTRL_COMMON_WRITE, SUBNET_MASK[31:24]};
            5'd16:   c = {REG_SUBR + 16'd1, CTRL_COMMON_WRITE, SUBNET_MASK[23:16]};
            5'd17:   c = {REG_SUBR + 16'd2, CTRL_COMMON_WRITE, SUBNET_MASK[15:8]};
            5'd18:   c = {REG_SUBR + 16'd3, CTRL_COMMON_WRITE, SUBNET_MASK[7:0]};
            5'd19:   c = {REG_S0_MR, CTRL_S0_WRITE, S0_MODE_UDP};
            5'd20:   c = {REG_S0_RXBUF_SIZE, CTRL_S0_WRITE, S0_BUF_KB};
            5'd21:   c = {REG_S0_TXBUF_SIZE, CTRL_S0_WRITE, S0_BUF_KB};
            5'd22:   c = {REG_S0_PORT, CTRL_S0_WRITE, SRC_PORT[15:8]};
            5'd23:   c = {REG_S0_PORT + 16'd1, CTRL_S0_WRITE, SRC_PORT[7:0]};
            5'd24:   c = {REG_S0_CR, CTRL_S0_WRITE, CMD_OPEN};
            5'd25:   c = {REG_S0_DIPR, CTRL_S0_WRITE, DST_IP[31:24]};
            5'd26:   c = {REG_S0_DIPR + 16'd1, CTRL_S0_WRITE, DST_IP[23:16]};
            5'd27:   c = {REG_S0_DIPR + 16'd2, CTRL_S0_WRITE, DST_IP[15:8]};
            5'd28:   c = {REG_S0_DIPR + 16'd3, CTRL_S0_WRITE, DST_IP[7:0]};
            5'd29:   c = {REG_S0_DPORT, CTRL_S0_WRITE, DST_PORT[15:8]};
            default: c = {REG_S0_DPORT + 16'd1, CTRL_S0_WRITE, DST_PORT[7:0]};
        endcase
        return c;
    endfunction

    always_comb begin
        case (state)
            SEQ_POLL:   cmd = {REG_S0_SR, CTRL_S0_READ, 8'h00};
            SEQ_PTR_LO: cmd = {REG_S0_TX_WR_LO, CTRL_S0_WRITE, tx_ptr[7:0]};
            SEQ_PTR_HI: cmd = {REG_S0_TX_WR_HI, CTRL_S0_WRITE, tx_ptr[15:8]};
            SEQ_SEND:   cmd = {REG_S0_CR, CTRL_S0_WRITE, CMD_SEND};
            default:    cmd = setup_cmd(step);
        endcase
    end

    // Command frames sit in the top bits and go out first
    assign frame = (state == SEQ_PUSH) ? {tx_ptr, CTRL_S0_TX_WRITE, payload_q}
                                       : {cmd, {(FRAME_BITS - CMD_BITS){1'b0}}};
    assign frame_len = (state == SEQ_PUSH) ? frame_len_t'(FRAME_BITS)
                                           : frame_len_t'(CMD_BITS);

    assign start = !in_flight && (state != SEQ_IDLE);
    assign pop = (state == SEQ_IDLE) && !empty;

    always_ff @(posedge clk) begin
        if (pop) begin
            payload_q <= head;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= SEQ_SETUP;
            step <= '0;
            in_flight <= 1'b0;
            tx_ptr <= '0;
            init_done <= 1'b0;
        end else begin
            if (start) begin
                in_flight <= 1'b1;
            end
            if (done) begin
                in_flight <= 1'b0;
                case (state)
                    SEQ_SETUP: begin
                        if (step == 5'(SETUP_STEPS - 1)) begin
                            state <= SEQ_POLL;
                        end else begin
                            step <= step + 5'd1;
                        end
                    end
                    SEQ_POLL: begin
                        // Socket not open yet, read the status again
                        if (rd_byte == SOCK_UDP) begin
                            state <= SEQ_IDLE;
                            init_done <= 1'b1;
                        end
                    end
                    SEQ_PUSH: begin
                        tx_ptr <= tx_ptr + ptr_t'(PAYLOAD_BYTES);
                        state <= SEQ_PTR_LO;
                    end
                    SEQ_PTR_LO: state <= SEQ_PTR_HI;
                    SEQ_PTR_HI: state <= SEQ_SEND;
                    SEQ_SEND:   state <= SEQ_IDLE;
                    default:    state <= state;
                endcase
            end else if (pop) begin
                state <= SEQ_PUSH;
            end
        end
    end

    a_pop_then_push: assert property (
        @(posedge clk) disable iff (!rst_n)
        pop |-> (state == SEQ_IDLE) ##1 (state == SEQ_PUSH && start)
    );

endmodule

`default_nettype wire

// ==== logic/payload_fifo.sv ====
`default_nettype none

module payload_fifo (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                push,
    input  w5500_pkg::payload_t wdata,
    input  logic                pop,
    output w5500_pkg::payload_t head,
    output logic                empty,
    output logic                overflow
);
    import w5500_pkg::*;

    payload_t                  mem [FIFO_DEPTH];
    logic [FIFO_ADDR_BITS-1:0] wr_ptr;
    logic [FIFO_ADDR_BITS-1:0] rd_ptr;
    logic [FIFO_ADDR_BITS:0]   count;
    logic                      full;
    logic                      wr_en;
    logic                      rd_en;

    assign empty = (count == '0);
    assign full = (count == (FIFO_ADDR_BITS + 1)'(FIFO_DEPTH));

    // A pop in the same cycle frees the slot for a push into a full FIFO
    assign wr_en = push && (!full || pop);
    assign rd_en = pop && !empty;
    assign overflow = push && full && !pop;

    assign head = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_pop_when_empty: assert property (
        @(posedge clk) disable iff (!rst_n) pop |-> !empty
    );

endmodule

`default_nettype wire

// ==== common/w5500_pkg.sv ====
`default_nettype none

package w5500_pkg;

    // Frame geometry
    localparam int PAYLOAD_BITS = 64;
    localparam int PAYLOAD_BYTES = PAYLOAD_BITS / 8;
    localparam int HEADER_BITS = 24;
    localparam int FRAME_BITS = HEADER_BITS + PAYLOAD_BITS;
    localparam int FRAME_LEN_BITS = $clog2(FRAME_BITS + 1);
    localparam int CMD_BITS = 32;

    typedef logic [PAYLOAD_BITS-1:0] payload_t;
    typedef logic [FRAME_BITS-1:0] frame_t;
    typedef logic [FRAME_LEN_BITS-1:0] frame_len_t;
    typedef logic [7:0] byte_t;
    typedef logic [15:0] ptr_t;

    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_ADDR_BITS = $clog2(FIFO_DEPTH);

    // 31 register writes before the first status read
    localparam int SETUP_STEPS = 31;

    // Block select plus read/write bit, variable length mode
    typedef enum logic [7:0] {
        CTRL_COMMON_WRITE = 8'h04,
        CTRL_S0_READ      = 8'h08,
        CTRL_S0_WRITE     = 8'h0C,
        CTRL_S0_TX_WRITE  = 8'h14
    } ctrl_t;

    typedef enum logic [2:0] {
        SEQ_SETUP,
        SEQ_POLL,
        SEQ_IDLE,
        SEQ_PUSH,
        SEQ_PTR_LO,
        SEQ_PTR_HI,
        SEQ_SEND
    } seq_state_t;

    localparam logic [47:0] MAC_ADDR = 48'hAA_AF_FA_CC_E3_1C;
    localparam logic [31:0] LOCAL_IP = {8'd192, 8'd168, 8'd10, 8'd194};
    localparam logic [31:0] GATEWAY_IP = {8'd192, 8'd168, 8'd10, 8'd1};
    localparam logic [31:0] SUBNET_MASK = {8'd255, 8'd255, 8'd255, 8'd0};
    localparam logic [15:0] SRC_PORT = 16'd2390;
    localparam logic [31:0] DST_IP = {8'd192, 8'd168, 8'd10, 8'd0};
    localparam logic [15:0] DST_PORT = 16'd2390;

    localparam byte_t SOCK_UDP = 8'h22;
    localparam byte_t S0_BUF_KB = 8'd16;

    // Common register block
    localparam logic [15:0] REG_PHYCFGR = 16'h002E;
    localparam logic [15:0] REG_SHAR = 16'h0009;
    localparam logic [15:0] REG_SIPR = 16'h000F;
    localparam logic [15:0] REG_GAR = 16'h0001;
    localparam logic [15:0] REG_SUBR = 16'h0005;

    // Socket 0 register block
    localparam logic [15:0] REG_S0_MR = 16'h0000;
    localparam logic [15:0] REG_S0_CR = 16'h0001;
    localparam logic [15:0] REG_S0_SR = 16'h0003;
    localparam logic [15:0] REG_S0_PORT = 16'h0004;
    localparam logic [15:0] REG_S0_DIPR = 16'h000C;
    localparam logic [15:0] REG_S0_DPORT = 16'h0010;
    localparam logic [15:0] REG_S0_RXBUF_SIZE = 16'h001E;
    localparam logic [15:0] REG_S0_TXBUF_SIZE = 16'h001F;
    localparam logic [15:0] REG_S0_TX_WR_HI = 16'h0024;
    localparam logic [15:0] REG_S0_TX_WR_LO = 16'h0025;

    // 100 Mbit full duplex, autonegotiation off
    localparam byte_t PHY_MODE = 8'hD8;
    localparam byte_t S0_MODE_UDP = 8'h02;
    localparam byte_t CMD_OPEN = 8'h01;
    localparam byte_t CMD_SEND = 8'h20;

endpackage

`default_nettype wire
